// ==== dv/qar_lite_stim.txt ====
// Hex words: program length, program words from pc 0 upward, expected store count,
// then expected stores as address/data pairs in program order
00000023
00500093 00708093 01308093 10102023 // addi x1,x0,5; addi x1,x1,7; addi x1,x1,19; sw x1,0x100
12345137 0F000193 00310233 10202223 // lui x2; addi x3,x0,0xf0; add x4,x2,x3; sw x2,0x104
10402423 401182B3 0011F333 0011E3B3 // sw x4,0x108; sub x5,x3,x1; and x6,x3,x1; or x7,x3,x1
0011C433 10502623 10602823 10702A23 // xor x8,x3,x1; sw x5,0x10c; sw x6,0x110; sw x7,0x114
10802C23 00400593 00B214B3 00B25533 // sw x8,0x118; addi x11,x0,4; sll x9,x4,x11; srl x10,x4,x11
10902E23 12A02023 07B00013 12002223 // sw x9,0x11c; sw x10,0x120; addi x0,x0,123; sw x0,0x124
00528463 1E102823 00631463 05500613 // beq x5,x5,+8; sw skipped; bne x6,x6,+8; addi x12,x0,0x55
00061463 1E102A23 008006EF 1E102C23 // bne x12,x0,+8; sw skipped; jal x13,+8; sw skipped
12C02423 12D02623 0000006F          // sw x12,0x128; sw x13,0x12c; jal x0,0
// Expected stores
0000000C
00000100 0000001F  00000104 12345000
00000108 123450F0  0000010C 000000D1
00000110 00000010  00000114 000000FF
00000118 000000EF  0000011C 23450F00
00000120 0123450F  00000124 00000000
00000128 00000055  0000012C 0000007C

// ==== dv/qar_lite_tb.sv ====
// Testbench for the qar_lite core
// Runs the program from the stim file and checks every store against the expected list
module qar_lite_tb;

    localparam int          stim_words = 256;
    localparam int          run_limit  = 2000;   // Cycles to see every expected store
    localparam int          quiet_time = 50;     // Cycles watched for extra stores
    localparam logic [31:0] nop_word   = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic        imem_valid;
    logic [31:0] imem_addr;
    logic        imem_ready = 1'b0;
    logic [31:0] imem_rdata = '0;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready  = 1'b0;

    logic [31:0] stim [0:stim_words-1];
    logic [31:0] rng_state    = 32'd55469;
    int          prog_len     = 0;
    int          exp_count    = 0;
    int          pair_base    = 0;      // Index of the first address/data pair
    int          store_count  = 0;
    int          value_errors = 0;
    int          extra_stores = 0;
    int          timeouts     = 0;
    logic        imem_busy    = 1'b0;
    int          imem_wait    = 0;
    logic        mem_busy     = 1'b0;
    int          mem_wait     = 0;
    int          cycles;

    qar_lite_top #(.reset_pc(32'h0)) uut (
        .clk(clk), .rst_n(rst_n),
        .imem_valid(imem_valid), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Delay in 0 .. span-1 cycles
    task automatic draw_delay(input int span, output int delay);
        rng_state = xorshift32(rng_state);
        delay     = rng_state % span;
    endtask

    // Words past the program read as NOP
    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len)
            return stim[1 + idx];
        return nop_word;
    endfunction

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        if (store_count >= exp_count) begin
            $display("Unexpected store at time %0t to address %h with data %h, beyond the list",
                     $time, addr, data);
            extra_stores++;
        end else begin
            exp_addr = stim[pair_base + 2 * store_count];
            exp_data = stim[pair_base + 2 * store_count + 1];
            if (addr !== exp_addr) begin
                $display("Error at time %0t: mem_addr got %h expected %h", $time, addr, exp_addr);
                value_errors++;
            end
            if (data !== exp_data) begin
                $display("Error at time %0t: mem_wdata got %h expected %h",
                         $time, data, exp_data);
                value_errors++;
            end
        end
        store_count++;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Memory models, both driven on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        // Ready high over a rising edge means that edge carried the transfer
        if (imem_ready) begin
            imem_ready = 1'b0;
            imem_busy  = 1'b0;
        end
        if (rst_n && imem_valid && !imem_busy) begin
            imem_busy = 1'b1;
            draw_delay(3, imem_wait);
        end
        if (imem_busy) begin
            if (imem_wait == 0) begin
                imem_ready = 1'b1;
                imem_rdata = prog_word(imem_addr);
            end else begin
                imem_wait = imem_wait - 1;
            end
        end

        if (mem_ready) begin
            mem_ready = 1'b0;
            mem_busy  = 1'b0;
        end
        if (rst_n && mem_valid && !mem_busy) begin
            mem_busy = 1'b1;
            draw_delay(4, mem_wait);
        end
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                check_store(mem_addr, mem_wdata);   // Transfers at the next rising edge
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst_n = 1'b0;
        $readmemh("dv/qar_lite_stim.txt", stim);
        prog_len  = int'(stim[0]);
        exp_count = int'(stim[prog_len + 1]);
        pair_base = prog_len + 2;
        if (prog_len == 0 || exp_count == 0) begin
            $display("Stim file gave no program or no expected stores");
            timeouts++;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (store_count < exp_count && cycles < run_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (store_count < exp_count) begin
            $display("Timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, store_count, exp_count);
            timeouts++;
        end

        // Program now spins in its final jump, so no store may follow
        cycles = 0;
        while (cycles < quiet_time) begin
            @(posedge clk);
            cycles++;
        end

        $display("Stores seen %0d, value errors %0d, extra stores %0d, timeouts %0d",
                 store_count, value_errors, extra_stores, timeouts);
        if (value_errors == 0 && extra_stores == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/qar_decode.sv ====
// Decode stage of the qar_lite core
// Register file read with writeback forwarding, and the decode-to-execute register
module qar_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qar_pkg::fetch_pkt_t  fetch_in,
    output logic                 dec_ready,
    input  qar_pkg::wb_t         wb,
    input  logic                 ex_stall,
    input  qar_pkg::redirect_t   redirect,
    output qar_pkg::decode_pkt_t dec_out
);

    logic [qar_pkg::xlen-1:0]       regs [0:31];
    logic [qar_pkg::reg_addr_w-1:0] rs1;
    logic [qar_pkg::reg_addr_w-1:0] rs2;
    logic [qar_pkg::xlen-1:0]       rs1_val;
    logic [qar_pkg::xlen-1:0]       rs2_val;
    qar_pkg::decode_pkt_t           dec_q;

    // Register read, x0 hardwired to zero
    function automatic logic [qar_pkg::xlen-1:0] read_src(
        input logic [qar_pkg::reg_addr_w-1:0] idx
    );
        if (idx == '0)
            return '0;
        else if (wb.we && wb.rd == idx)
            return wb.data;     // Execute writes it at this very edge
        else
            return regs[idx];
    endfunction

    assign rs1 = fetch_in.instr[19:15];
    assign rs2 = fetch_in.instr[24:20];

    always_comb begin
        rs1_val = read_src(rs1);
        rs2_val = read_src(rs2);
    end

    // -------------------------------------------------------------------------
    // Register file
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wb.we && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

    // -------------------------------------------------------------------------
    // Decode-to-execute register
    // -------------------------------------------------------------------------
    // Moves when empty or when execute lets go of it
    assign dec_ready = !dec_q.valid || !ex_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_q <= '0;
        end else if (redirect.taken) begin
            dec_q.valid <= 1'b0;     // Wrong-path instruction
        end else if (dec_ready) begin
            dec_q.valid   <= fetch_in.valid;
            dec_q.pc      <= fetch_in.pc;
            dec_q.instr   <= fetch_in.instr;
            dec_q.rs1_val <= rs1_val;
            dec_q.rs2_val <= rs2_val;
        end
    end

    assign dec_out = dec_q;

endmodule

// ==== logic/qar_execute.sv ====
// Execute stage of the qar_lite core
// ALU, branch resolution, same-cycle writeback and the store request register
module qar_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  qar_pkg::decode_pkt_t dec_in,
    output qar_pkg::wb_t         wb,
    output qar_pkg::redirect_t   redirect,
    output logic                 ex_stall,
    output qar_pkg::store_req_t  store_req,
    input  logic                 mem_ready
);

    qar_pkg::opcode_t               opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [qar_pkg::reg_addr_w-1:0] rd;
    logic [qar_pkg::xlen-1:0]       imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [qar_pkg::xlen-1:0]       pc_plus4;

    qar_pkg::alu_op_t               op_alu;     // Function of an OP instruction
    qar_pkg::alu_op_t               alu_sel;
    logic                           op_ok;
    logic [qar_pkg::xlen-1:0]       alu_b;
    logic [qar_pkg::xlen-1:0]       alu_res;

    logic                           is_store;
    logic                           store_go;
    qar_pkg::store_req_t            store_q;

    assign opcode = qar_pkg::opcode_t'(dec_in.instr[6:0]);
    assign funct3 = dec_in.instr[14:12];
    assign funct7 = dec_in.instr[31:25];
    assign rd     = dec_in.instr[11:7];

    assign imm_i = {{20{dec_in.instr[31]}}, dec_in.instr[31:20]};
    assign imm_s = {{20{dec_in.instr[31]}}, dec_in.instr[31:25], dec_in.instr[11:7]};
    assign imm_b = {{20{dec_in.instr[31]}}, dec_in.instr[7], dec_in.instr[30:25],
                    dec_in.instr[11:8], 1'b0};
    assign imm_j = {{12{dec_in.instr[31]}}, dec_in.instr[19:12], dec_in.instr[20],
                    dec_in.instr[30:21], 1'b0};
    assign imm_u = {dec_in.instr[31:12], 12'b0};
    assign pc_plus4 = dec_in.pc + 32'd4;

    // -------------------------------------------------------------------------
    // ALU
    // -------------------------------------------------------------------------
    always_comb begin
        op_alu = qar_pkg::alu_add;
        op_ok  = (funct7 == 7'b0000000);
        case (funct3)
            3'b000: begin
                op_alu = funct7[5] ? qar_pkg::alu_sub : qar_pkg::alu_add;
                op_ok  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end
            3'b111: op_alu = qar_pkg::alu_and;
            3'b110: op_alu = qar_pkg::alu_or;
            3'b100: op_alu = qar_pkg::alu_xor;
            3'b001: op_alu = qar_pkg::alu_sll;
            3'b101: op_alu = qar_pkg::alu_srl;
            default: op_ok = 1'b0;        // SLT/SLTU not kept
        endcase
    end

    assign alu_sel = (opcode == qar_pkg::opc_op) ? op_alu : qar_pkg::alu_add;
    assign alu_b   = (opcode == qar_pkg::opc_op) ? dec_in.rs2_val : imm_i;

    always_comb begin
        case (alu_sel)
            qar_pkg::alu_sub: alu_res = dec_in.rs1_val - alu_b;
            qar_pkg::alu_and: alu_res = dec_in.rs1_val & alu_b;
            qar_pkg::alu_or:  alu_res = dec_in.rs1_val | alu_b;
            qar_pkg::alu_xor: alu_res = dec_in.rs1_val ^ alu_b;
            qar_pkg::alu_sll: alu_res = dec_in.rs1_val << alu_b[4:0];
            qar_pkg::alu_srl: alu_res = dec_in.rs1_val >> alu_b[4:0];
            default:          alu_res = dec_in.rs1_val + alu_b;
        endcase
    end

    // -------------------------------------------------------------------------
    // Control, writeback and redirect
    // -------------------------------------------------------------------------
    always_comb begin
        wb.we           = 1'b0;
        wb.rd           = rd;
        wb.data         = alu_res;
        redirect.taken  = 1'b0;
        redirect.target = dec_in.pc + imm_b;
        is_store        = 1'b0;
        if (dec_in.valid) begin
            case (opcode)
                qar_pkg::opc_op:     wb.we = op_ok;
                qar_pkg::opc_op_imm: wb.we = (funct3 == 3'b000);   // ADDI
                qar_pkg::opc_lui: begin
                    wb.we   = 1'b1;
                    wb.data = imm_u;
                end
                qar_pkg::opc_store:  is_store = (funct3 == 3'b010);
                qar_pkg::opc_branch: begin
                    if (funct3 == 3'b000)
                        redirect.taken = (dec_in.rs1_val == dec_in.rs2_val);
                    else if (funct3 == 3'b001)
                        redirect.taken = (dec_in.rs1_val != dec_in.rs2_val);
                end
                qar_pkg::opc_jal: begin
                    wb.we           = 1'b1;
                    wb.data         = pc_plus4;      // Link value
                    redirect.taken  = 1'b1;
                    redirect.target = dec_in.pc + imm_j;
                end
                default: ;                       // Outside the subset, retires as no-op
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Store request register
    // -------------------------------------------------------------------------
    // A second store waits until the pending one transfers
    assign ex_stall = is_store && store_q.valid && !mem_ready;
    assign store_go = is_store && !ex_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_q <= '0;
        end else if (store_go) begin
            store_q.valid <= 1'b1;
            store_q.addr  <= dec_in.rs1_val + imm_s;
            store_q.wdata <= dec_in.rs2_val;
        end else if (store_q.valid && mem_ready) begin
            store_q.valid <= 1'b0;
        end
    end

    assign store_req = store_q;

endmodule

// ==== logic/qar_fetch.sv ====
// Fetch stage of the qar_lite core
// One open request on the instruction port and a one-entry instruction buffer
module qar_fetch #(
    parameter logic [qar_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  qar_pkg::redirect_t       redirect,
    input  logic                     dec_ready,
    output logic                     imem_valid,
    output logic [qar_pkg::xlen-1:0] imem_addr,
    input  logic                     imem_ready,
    input  logic [qar_pkg::xlen-1:0] imem_rdata,
    output qar_pkg::fetch_pkt_t      fetch_out
);

    logic [qar_pkg::xlen-1:0] pc;           // Next address to request
    logic                     req_pending;
    logic [qar_pkg::xlen-1:0] req_addr;
    logic                     discard;      // Open request went stale on a redirect
    qar_pkg::fetch_pkt_t      ibuf;

    logic imem_xfer;
    logic buf_take;
    logic issue;

    assign imem_xfer = req_pending && imem_ready;
    assign buf_take  = ibuf.valid && dec_ready;

    // Only one request open, and only when its word has somewhere to go
    assign issue = !req_pending && (!ibuf.valid || buf_take) && !redirect.taken;

    // -------------------------------------------------------------------------
    // Request side
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= reset_pc;
            req_pending <= 1'b0;
            req_addr    <= reset_pc;
            discard     <= 1'b0;
        end else begin
            if (imem_xfer) begin
                req_pending <= 1'b0;
                discard     <= 1'b0;
            end else if (issue) begin
                req_pending <= 1'b1;
                req_addr    <= pc;
                pc          <= pc + 32'd4;
            end
            if (redirect.taken) begin
                pc <= redirect.target;
                // Valid must stay up until ready, so mark the word for dropping
                if (req_pending && !imem_xfer)
                    discard <= 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Instruction buffer
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ibuf <= '0;
        end else if (redirect.taken) begin
            ibuf.valid <= 1'b0;
        end else if (imem_xfer && !discard) begin
            ibuf.valid <= 1'b1;
            ibuf.pc    <= req_addr;
            ibuf.instr <= imem_rdata;
        end else if (buf_take) begin
            ibuf.valid <= 1'b0;
        end
    end

    assign imem_valid = req_pending;
    assign imem_addr  = req_addr;
    assign fetch_out  = ibuf;

endmodule

// ==== logic/qar_lite_top.sv ====
// qar_lite core top level
// Joins fetch, decode and execute to the instruction and data ports
module qar_lite_top #(
    parameter logic [qar_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     imem_valid,
    output logic [qar_pkg::xlen-1:0] imem_addr,
    input  logic                     imem_ready,
    input  logic [qar_pkg::xlen-1:0] imem_rdata,
    output logic                     mem_valid,
    output logic [qar_pkg::xlen-1:0] mem_addr,
    output logic [qar_pkg::xlen-1:0] mem_wdata,
    input  logic                     mem_ready
);

    qar_pkg::fetch_pkt_t  fetch_pkt;
    qar_pkg::decode_pkt_t dec_pkt;
    qar_pkg::wb_t         wb;
    qar_pkg::redirect_t   redirect;
    qar_pkg::store_req_t  store_req;
    logic                 dec_ready;
    logic                 ex_stall;

    qar_fetch #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .rst_n(rst_n),
        .redirect(redirect), .dec_ready(dec_ready),
        .imem_valid(imem_valid), .imem_addr(imem_addr),
        .imem_ready(imem_ready), .imem_rdata(imem_rdata),
        .fetch_out(fetch_pkt)
    );

    qar_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .fetch_in(fetch_pkt), .dec_ready(dec_ready),
        .wb(wb), .ex_stall(ex_stall), .redirect(redirect),
        .dec_out(dec_pkt)
    );

    qar_execute u_execute (
        .clk(clk), .rst_n(rst_n),
        .dec_in(dec_pkt), .wb(wb), .redirect(redirect),
        .ex_stall(ex_stall), .store_req(store_req), .mem_ready(mem_ready)
    );

    // Every data access is a store
    assign mem_valid = store_req.valid;
    assign mem_addr  = store_req.addr;
    assign mem_wdata = store_req.wdata;

endmodule

// ==== logic/qar_pkg.sv ====
// Shared definitions for the qar_lite three-stage core
// Opcodes, ALU codes, widths and the packets passed between stages
package qar_pkg;

    // -------------------------------------------------------------------------
    // Widths
    // -------------------------------------------------------------------------
    localparam int xlen       = 32;   // Data and address width
    localparam int reg_addr_w = 5;    // Register index

    // -------------------------------------------------------------------------
    // Encodings
    // -------------------------------------------------------------------------
    // Major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // Register ALU ops
        opc_op_imm = 7'b0010011,  // Only ADDI is kept
        opc_lui    = 7'b0110111,
        opc_store  = 7'b0100011,  // SW only
        opc_branch = 7'b1100011,  // BEQ and BNE
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl
    } alu_op_t;

    // -------------------------------------------------------------------------
    // Stage packets
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_pkt_t;

    // Operands already read and forwarded in decode
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
    } decode_pkt_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } store_req_t;

endpackage

// ==== qar_lite.f ====
logic/qar_pkg.sv
logic/qar_fetch.sv
logic/qar_decode.sv
logic/qar_execute.sv
logic/qar_lite_top.sv
dv/qar_lite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the qar_lite testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 --top-module qar_lite_tb \
        -f qar_lite.f -o qar_lite_sim \
    && ./obj_dir/qar_lite_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
    && echo "qar_lite simulation passed" \
    || { echo "qar_lite simulation did not pass"; exit 1; }
exit 0
